// File: files.f
+incdir+hw
hw/flacSamplePkg.sv
hw/flacStreamPkg.sv
hw/blockAnalyzer.sv
hw/residualEncoder.sv
hw/riceCoder.sv
hw/flacEncoder.sv
tests/flacEncoder_assert.sv
tests/flacEncoderTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module flacEncoderTb -o flacSim || exit 1
./obj_dir/flacSim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// File: tests/flacEncoderTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "flac_defines.svh"

module flacEncoderTb;
    import flacSamplePkg::*;
    import flacStreamPkg::*;

    localparam int numBlocks = 29;
    localparam int pauseCycles = 40;
    localparam int cycleLimit = numBlocks * 2 * `BLOCK_SIZE + pauseCycles + 200;

    logic         clock;
    logic         arstN;
    logic         enable;
    sample_t      sample;
    logic         valid;
    ramWrite_t    ram1;
    ramWrite_t    ram2;
    logic [31:0]  lfsr = 32'he21a7233;
    sample_t      blk [`BLOCK_SIZE];
    word_t        expWords [$];
    string        wordTests [$];
    blockHeader_t expHeaders [$];
    string        headerTests [$];
    word_t        packWord;
    int           packFill;
    int           packCount;
    string        packName;
    int           escapeCount;
    int           blocksSent;
    int           headersSeen;
    wordAddr_t    nextAddr;
    logic         enablePrev;
    word_t        wantWord;
    blockHeader_t wantHeader;
    string        checkName;
    int           cycleCount;
    int           dataErrors;
    int           headerErrors;
    int           otherErrors;

    flacEncoder dut0 (
        .clock(clock),
        .arstN(arstN),
        .enable(enable),
        .sample(sample),
        .valid(valid),
        .ram1(ram1),
        .ram2(ram2)
    );

    bind flacEncoder flacEncoderAssert assert0 (
        .clock(clock),
        .arstN(arstN),
        .valid(valid),
        .ram1(ram1),
        .ram2(ram2)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) r = {r[30:0], lfsrStep()};
        return r;
    endfunction

    function automatic sample_t smallNoise(input int width);
        int v;
        v = int'(randomBits(width));
        if (v >= (1 << (width - 1))) v -= (1 << width);  // Two's complement of width bits.
        return sample_t'(v);
    endfunction

    function automatic int predictError(input int ord, input int n);
        int x [4];
        for (int i = 0; i < 4; i++) begin
            x[i] = 0;
            if (n >= i) x[i] = int'(blk[n - i]);  // Zero history before the block.
        end
        case (ord)
            0: return x[0];
            1: return x[0] - x[1];
            2: return x[0] - 2 * x[1] + x[2];
            default: return x[0] - 3 * x[1] + 3 * x[2] - x[3];
        endcase
    endfunction

    function automatic int zigzag(input int e);
        return (e >= 0) ? 2 * e : -2 * e - 1;
    endfunction

    function automatic void packBit(input logic b);
        packWord = {packWord[14:0], b};
        packFill++;
        if (packFill == 16) begin
            expWords.push_back(packWord);
            wordTests.push_back(packName);
            packCount++;
            packFill = 0;
        end
    endfunction

    // Expected words go to the queues, the header is also returned.
    function automatic blockHeader_t encodeBlock(input string name);
        longint       sums [4];
        int           best;
        int           k;
        int           u;
        int           q;
        blockHeader_t hdr;
        for (int ord = 0; ord < 4; ord++) begin
            sums[ord] = 0;
            for (int n = 0; n < `BLOCK_SIZE; n++) sums[ord] += zigzag(predictError(ord, n));
        end
        best = 0;
        for (int ord = 1; ord < 4; ord++) begin
            if (sums[ord] < sums[best]) best = ord;
        end
        k = `MAX_RICE;
        for (int i = `MAX_RICE; i >= 0; i--) begin
            if ((longint'(`BLOCK_SIZE) << i) >= sums[best]) k = i;
        end
        packName = name;
        packFill = 0;
        packCount = 0;
        packWord = '0;
        for (int n = 0; n < `BLOCK_SIZE; n++) begin
            u = zigzag(predictError(best, n));
            q = u >> k;
            if (q < `ESCAPE_QUOTIENT) begin
                repeat (q) packBit(1'b0);
                packBit(1'b1);
                for (int b = k - 1; b >= 0; b--) packBit(u[b]);
            end else begin
                escapeCount++;
                repeat (`ESCAPE_QUOTIENT) packBit(1'b0);
                for (int b = 19; b >= 0; b--) packBit(u[b]);
            end
        end
        while (packFill != 0) packBit(1'b0);
        hdr.order = 2'(best);
        hdr.riceParam = 4'(k);
        hdr.wordCount = 10'(packCount);
        expHeaders.push_back(hdr);
        headerTests.push_back(name);
        return hdr;
    endfunction

    task automatic sendSample(input sample_t s);
        @(posedge clock);
        sample <= s;
        valid <= 1'b1;
        @(posedge clock);
        valid <= 1'b0;
    endtask

    task automatic sendBlock(input string name, input int wantOrder, input int pauseAt);
        blockHeader_t hdr;
        hdr = encodeBlock(name);
        if (wantOrder >= 0 && int'(hdr.order) != wantOrder) begin
            headerErrors++;
            $display("ERR %s reference order expected %0d actual %0d", name, wantOrder, hdr.order);
        end
        blocksSent++;
        for (int n = 0; n < `BLOCK_SIZE; n++) begin
            if (n == pauseAt) begin
                @(posedge clock);
                enable <= 1'b0;
                repeat (pauseCycles) @(posedge clock);
                enable <= 1'b1;
            end
            sendSample(blk[n]);
        end
    endtask

    always @(negedge clock) begin
        if (ram1.enable) begin
            if (!enablePrev) begin
                otherErrors++;
                $display("Data write while the encoder was paused");
            end
            if (expWords.size() == 0) begin
                otherErrors++;
                $display("Unexpected data write at address %h", ram1.addr);
            end else begin
                wantWord = expWords.pop_front();
                checkName = wordTests.pop_front();
                if (ram1.data !== wantWord) begin
                    dataErrors++;
                    $display("ERR %s data expected %h actual %h", checkName, wantWord, ram1.data);
                end
                if (ram1.addr !== nextAddr) begin
                    dataErrors++;
                    $display("ERR %s address expected %h actual %h", checkName, nextAddr,
                             ram1.addr);
                end
            end
            nextAddr++;
        end
        if (ram2.enable) begin
            if (expHeaders.size() == 0) begin
                otherErrors++;
                $display("Unexpected header write at address %h", ram2.addr);
            end else begin
                wantHeader = expHeaders.pop_front();
                checkName = headerTests.pop_front();
                if (ram2.data !== word_t'(wantHeader) || ram2.addr !== wordAddr_t'(headersSeen)) begin
                    headerErrors++;
                    $display("ERR %s header expected %h@%0d actual %h@%0d", checkName,
                             word_t'(wantHeader), headersSeen, ram2.data, ram2.addr);
                end
            end
            headersSeen++;
        end
        enablePrev = enable;  // Writes lag enable by one clock.
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, %0d of %0d headers written", cycleCount,
                 headersSeen, blocksSent);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          pos;
        int          amp;
        logic [31:0] spikeBits;
        escapeCount = 0;
        blocksSent = 0;
        headersSeen = 0;
        nextAddr = '0;
        enablePrev = 1'b0;
        dataErrors = 0;
        headerErrors = 0;
        otherErrors = 0;
        arstN <= 1'b0;
        enable <= 1'b0;
        valid <= 1'b0;
        sample <= '0;
        repeat (3) @(posedge clock);
        arstN <= 1'b1;
        enable <= 1'b1;
        blk = '{default: '0};
        sendBlock("zero", 0, -1);
        for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = sample_t'(100 + 37 * n);
        sendBlock("ramp", 2, -1);
        for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = sample_t'(5 * n * n);
        sendBlock("quadratic", 3, -1);
        repeat (2) begin
            for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = sample_t'(randomBits(16));
            sendBlock("fullScale", -1, -1);
        end
        // One large spike in quiet noise forces an escape.
        repeat (3) begin
            pos = int'(randomBits(4));
            for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = smallNoise(2);
            spikeBits = randomBits(15);
            blk[pos] = sample_t'({spikeBits[14], ~spikeBits[14], spikeBits[13:0]});
            sendBlock("spike", -1, -1);
        end
        repeat (20) begin
            amp = 1 + int'(randomBits(4)) % 12;
            for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = smallNoise(amp);
            sendBlock("noise", -1, -1);
        end
        for (int n = 0; n < `BLOCK_SIZE; n++) blk[n] = smallNoise(6);
        sendBlock("pause", -1, 7);
        wait (headersSeen == blocksSent);
        repeat (4) @(posedge clock);
        if (expWords.size() != 0) begin
            otherErrors++;
            $display("%0d expected data words were never written", expWords.size());
        end
        if (escapeCount == 0) begin
            otherErrors++;
            $display("No block exercised an escape code");
        end
        $display("Errors: data %0d, header %0d, other %0d", dataErrors, headerErrors,
                 otherErrors);
        if (dataErrors + headerErrors + otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/flacEncoder_assert.sv
`timescale 1ns/100ps
`default_nettype none

module flacEncoderAssert (
    input logic                     clock,
    input logic                     arstN,
    input logic                     valid,
    input flacStreamPkg::ramWrite_t ram1,
    input flacStreamPkg::ramWrite_t ram2
);
    import flacStreamPkg::*;

    wordAddr_t    lastAddr;
    logic         written;
    logic [9:0]   blockWords;
    blockHeader_t header;

    assign header = blockHeader_t'(ram2.data);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            lastAddr <= '0;
            written <= 1'b0;
            blockWords <= '0;
        end else if (ram1.enable) begin
            lastAddr <= ram1.addr;  // Address of the previous data write.
            written <= 1'b1;
            blockWords <= ram2.enable ? '0 : blockWords + 1'b1;  // Words of the current block.
        end
    end

    validSpacing: assert property (@(posedge clock) disable iff (!arstN) valid |=> !valid)
        else $error("valid was high on two consecutive cycles");

    addrStep: assert property (@(posedge clock) disable iff (!arstN)
        ram1.enable && written |-> ram1.addr == wordAddr_t'(lastAddr + 1'b1))
        else $error("data address did not advance by one");

    headerWithData: assert property (@(posedge clock) disable iff (!arstN)
        ram2.enable |-> ram1.enable && header.wordCount == blockWords + 1'b1)
        else $error("header write without its final data write or with a wrong word count");

endmodule

`default_nettype wire

// File: hw/flacEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module flacEncoder (
    input  logic                     clock,
    input  logic                     arstN,
    input  logic                     enable,
    input  flacSamplePkg::sample_t   sample,
    input  logic                     valid,
    output flacStreamPkg::ramWrite_t ram1,
    output flacStreamPkg::ramWrite_t ram2
);
    import flacSamplePkg::*;

    replay_t    replay;
    logic       replayValid;
    order_t     analyzedOrder;
    riceParam_t analyzedRice;
    foldedRes_t folded;
    logic       foldedValid;
    order_t     codedOrder;
    riceParam_t codedRice;

    blockAnalyzer analyzer0 (
        .clock(clock),
        .arstN(arstN),
        .enable(enable),
        .sample(sample),
        .valid(valid),
        .replay(replay),
        .replayValid(replayValid),
        .order(analyzedOrder),
        .riceParam(analyzedRice)
    );

    residualEncoder residual0 (
        .clock(clock),
        .arstN(arstN),
        .enable(enable),
        .replay(replay),
        .replayValid(replayValid),
        .orderIn(analyzedOrder),
        .riceIn(analyzedRice),
        .folded(folded),
        .foldedValid(foldedValid),
        .riceParam(codedRice),
        .order(codedOrder)
    );

    riceCoder coder0 (
        .clock(clock),
        .arstN(arstN),
        .enable(enable),
        .folded(folded),
        .foldedValid(foldedValid),
        .riceParam(codedRice),
        .order(codedOrder),
        .ram1(ram1),
        .ram2(ram2)
    );

endmodule

`default_nettype wire

// File: hw/riceCoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "flac_defines.svh"

module riceCoder (
    input  logic                      clock,
    input  logic                      arstN,
    input  logic                      enable,
    input  flacSamplePkg::foldedRes_t folded,
    input  logic                      foldedValid,
    input  flacSamplePkg::riceParam_t riceParam,
    input  flacSamplePkg::order_t     order,
    output flacStreamPkg::ramWrite_t  ram1,
    output flacStreamPkg::ramWrite_t  ram2
);
    import flacSamplePkg::*;
    import flacStreamPkg::*;

    logic [47:0]  acc;
    logic [47:0]  accNext;
    logic [5:0]   fill;
    logic [5:0]   fillAfter;
    logic [5:0]   fillNext;
    logic [3:0]   padBits;
    folded_t      quotient;
    logic         escape;
    logic [27:0]  code;
    logic [4:0]   codeLen;
    logic         drain;
    logic         finalWord;
    word_t        wordOut;
    logic [1:0]   tailWords;
    logic [9:0]   wordCount;
    wordAddr_t    dataAddr;
    wordAddr_t    blockIdx;
    wordAddr_t    ram1Addr;
    wordAddr_t    ram2Addr;
    logic         ram1En;
    logic         ram2En;
    word_t        ram1Data;
    blockHeader_t header;
    order_t       hdrOrder;
    riceParam_t   hdrRice;

    always_comb begin
        drain = (fill >= 6'd16);
        wordOut = word_t'(acc >> (fill - 6'd16));  // Oldest pending bits.
        fillAfter = drain ? fill - 6'd16 : fill;
        quotient = folded.value >> riceParam;
        escape = (quotient >= folded_t'(`ESCAPE_QUOTIENT));
        if (escape) begin
            code = 28'(folded.value);
            codeLen = 5'(`ESCAPE_QUOTIENT + 20);
        end else begin
            code = (28'd1 << riceParam) | 28'(folded.value & ((20'd1 << riceParam) - 20'd1));
            codeLen = 5'(quotient) + 5'd1 + 5'(riceParam);
        end
        accNext = acc;
        fillNext = fillAfter;
        padBits = '0;
        if (foldedValid) begin
            accNext = (acc << codeLen) | 48'(code);
            fillNext = fillAfter + 6'(codeLen);
            if (folded.last) begin
                // Pad the block out to a whole word.
                padBits = 4'd0 - fillNext[3:0];
                accNext = accNext << padBits;
                fillNext = fillNext + 6'(padBits);
            end
        end
        finalWord = drain && (tailWords == 2'd1);
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            fill <= '0;
            tailWords <= '0;
            wordCount <= '0;
            dataAddr <= '0;
            blockIdx <= '0;
            ram1Addr <= '0;
            ram2Addr <= '0;
            ram1En <= 1'b0;
            ram2En <= 1'b0;
        end else begin
            ram1En <= 1'b0;  // Writes are single-cycle pulses.
            ram2En <= 1'b0;
            if (enable) begin
                fill <= fillNext;
                ram1En <= drain;
                ram2En <= finalWord;
                if (drain) begin
                    ram1Addr <= dataAddr;
                    dataAddr <= dataAddr + 1'b1;
                    wordCount <= finalWord ? '0 : wordCount + 1'b1;
                end
                if (finalWord) begin
                    ram2Addr <= blockIdx;
                    blockIdx <= blockIdx + 1'b1;
                end
                if (foldedValid && folded.last) begin
                    tailWords <= fillNext[5:4];  // Words left in this block.
                end else if (drain && tailWords != '0) begin
                    tailWords <= tailWords - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            acc <= accNext;
            if (drain) ram1Data <= wordOut;
            if (finalWord) header <= '{order: hdrOrder, riceParam: hdrRice,
                                       wordCount: wordCount + 1'b1};
            if (foldedValid && folded.last) begin
                hdrOrder <= order;
                hdrRice <= riceParam;
            end
        end
    end

    assign ram1 = '{enable: ram1En, addr: ram1Addr, data: ram1Data};
    assign ram2 = '{enable: ram2En, addr: ram2Addr, data: word_t'(header)};

endmodule

`default_nettype wire

// File: hw/residualEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module residualEncoder (
    input  logic                      clock,
    input  logic                      arstN,
    input  logic                      enable,
    input  flacSamplePkg::replay_t    replay,
    input  logic                      replayValid,
    input  flacSamplePkg::order_t     orderIn,
    input  flacSamplePkg::riceParam_t riceIn,
    output flacSamplePkg::foldedRes_t folded,
    output logic                      foldedValid,
    output flacSamplePkg::riceParam_t riceParam,
    output flacSamplePkg::order_t     order
);
    import flacSamplePkg::*;

    sample_t hist [3];
    folded_t foldedValue;

    assign foldedValue = fold(fixedResidual(orderIn, replay.sample, hist[0], hist[1], hist[2]));

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            foldedValid <= 1'b0;
            hist <= '{default: '0};
        end else if (enable) begin
            foldedValid <= replayValid;
            if (replayValid) begin
                if (replay.last) begin
                    hist <= '{default: '0};  // Zero history for the next block.
                end else begin
                    hist <= '{replay.sample, hist[0], hist[1]};
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable && replayValid) begin
            folded <= '{value: foldedValue, last: replay.last};
            riceParam <= riceIn;
            order <= orderIn;
        end
    end

endmodule

`default_nettype wire

// File: hw/blockAnalyzer.sv
`timescale 1ns/100ps
`default_nettype none

`include "flac_defines.svh"

module blockAnalyzer (
    input  logic                      clock,
    input  logic                      arstN,
    input  logic                      enable,
    input  flacSamplePkg::sample_t    sample,
    input  logic                      valid,
    output flacSamplePkg::replay_t    replay,
    output logic                      replayValid,
    output flacSamplePkg::order_t     order,
    output flacSamplePkg::riceParam_t riceParam
);
    import flacSamplePkg::*;

    localparam int idxBits = $clog2(`BLOCK_SIZE);
    localparam logic [idxBits-1:0] lastIdx = idxBits'(`BLOCK_SIZE - 1);

    typedef enum logic {idle, replaying} replayState_t;

    sample_t            buffer [2*`BLOCK_SIZE];
    logic               writeHalf;
    logic [idxBits-1:0] writeIdx;
    logic               readHalf;
    logic [idxBits-1:0] readIdx;
    logic               tick;
    replayState_t       state;
    sample_t            hist [3];
    costSum_t           sums [4];
    costSum_t           nextSums [4];
    costSum_t           bestSum;
    order_t             bestOrder;
    riceParam_t         bestRice;
    logic               blockEnd;

    assign blockEnd = valid && (writeIdx == lastIdx);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            nextSums[i] = sums[i]
                + costSum_t'(fold(fixedResidual(order_t'(i), sample, hist[0], hist[1], hist[2])));
        end
        bestOrder = '0;
        bestSum = nextSums[0];
        for (int i = 1; i < 4; i++) begin
            if (nextSums[i] < bestSum) begin  // Strict compare keeps the lower order on a tie.
                bestOrder = order_t'(i);
                bestSum = nextSums[i];
            end
        end
        bestRice = riceParam_t'(`MAX_RICE);
        for (int k = `MAX_RICE; k >= 0; k--) begin
            if ((costSum_t'(`BLOCK_SIZE) << k) >= bestSum) bestRice = riceParam_t'(k);
        end
    end

    always_ff @(posedge clock) begin
        if (enable && valid) buffer[{writeHalf, writeIdx}] <= sample;
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            writeHalf <= 1'b0;
            writeIdx <= '0;
            hist <= '{default: '0};
            sums <= '{default: '0};
            order <= '0;
            riceParam <= '0;
        end else if (enable && valid) begin
            if (blockEnd) begin
                writeHalf <= !writeHalf;  // Next block fills the other half.
                writeIdx <= '0;
                hist <= '{default: '0};
                sums <= '{default: '0};
                order <= bestOrder;
                riceParam <= bestRice;
            end else begin
                writeIdx <= writeIdx + 1'b1;
                hist <= '{sample, hist[0], hist[1]};
                sums <= nextSums;
            end
        end
    end

    // One stored sample every second cycle.
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            readHalf <= 1'b0;
            readIdx <= '0;
            tick <= 1'b0;
            replayValid <= 1'b0;
        end else if (enable) begin
            replayValid <= 1'b0;
            case (state)
                idle: begin
                    if (blockEnd) begin
                        state <= replaying;
                        readHalf <= writeHalf;
                        readIdx <= '0;
                        tick <= 1'b0;
                    end
                end
                replaying: begin
                    tick <= !tick;
                    if (!tick) begin
                        replayValid <= 1'b1;
                        readIdx <= readIdx + 1'b1;
                        if (readIdx == lastIdx) state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (enable && state == replaying && !tick) begin
            replay <= '{sample: buffer[{readHalf, readIdx}], last: readIdx == lastIdx};
        end
    end

endmodule

`default_nettype wire

// File: hw/flacStreamPkg.sv
`default_nettype none

package flacStreamPkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] wordAddr_t;

    // One header word per block.
    typedef struct packed {
        logic [1:0] order;
        logic [3:0] riceParam;
        logic [9:0] wordCount;
    } blockHeader_t;

    typedef struct packed {
        logic      enable;
        wordAddr_t addr;
        word_t     data;
    } ramWrite_t;

endpackage

`default_nettype wire

// File: hw/flacSamplePkg.sv
`default_nettype none

package flacSamplePkg;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [19:0] residual_t;  // Order 3 spans eight times the sample range.
    typedef logic [19:0] folded_t;
    typedef logic [23:0] costSum_t;
    typedef logic [1:0] order_t;
    typedef logic [3:0] riceParam_t;

    typedef struct packed {
        sample_t sample;
        logic    last;
    } replay_t;

    typedef struct packed {
        folded_t value;
        logic    last;
    } foldedRes_t;

    // Fixed predictor residual, x1..x3 are the previous samples.
    function automatic residual_t fixedResidual(order_t ord, sample_t x0, sample_t x1,
                                                sample_t x2, sample_t x3);
        residual_t a0;
        residual_t a1;
        residual_t a2;
        residual_t a3;
        a0 = residual_t'(x0);
        a1 = residual_t'(x1);
        a2 = residual_t'(x2);
        a3 = residual_t'(x3);
        case (ord)
            2'd0: return a0;
            2'd1: return a0 - a1;
            2'd2: return a0 - (a1 <<< 1) + a2;
            default: return a0 - 3 * a1 + 3 * a2 - a3;
        endcase
    endfunction

    // Zigzag fold: 2e for e >= 0, -2e-1 otherwise.
    function automatic folded_t fold(residual_t r);
        return {r[18:0], 1'b0} ^ {20{r[19]}};
    endfunction

endpackage

`default_nettype wire

// File: hw/flac_defines.svh
`ifndef FLAC_DEFINES_SVH
`define FLAC_DEFINES_SVH

// Samples per block.
`define BLOCK_SIZE 16

// Quotients at or above this are sent as raw 20-bit values.
`define ESCAPE_QUOTIENT 8

// Largest Rice parameter the analyzer may pick.
`define MAX_RICE 14

`endif
